// ==== hdl/chan_mux_params.svh ====
// ================================================
// Channel mux sizing
// Channel counts, sample width and index widths.
// ================================================

`ifndef CHAN_MUX_PARAMS_SVH
`define CHAN_MUX_PARAMS_SVH

// Channel counts.
`define CHAN_MUX_IN_CHANNELS 8
`define CHAN_MUX_OUT_CHANNELS 4

// One sample.
`define CHAN_MUX_SAMPLE_WIDTH 16

// Index widths, sized for the counts above.
`define CHAN_MUX_SELECT_BITS 3
`define CHAN_MUX_OUT_BITS 2

// Output samples dropped after a source switch.
`define CHAN_MUX_BLANK_CYCLES 2

`endif

// ==== hdl/chan_cfg_pkg.sv ====
// ================================================
// Channel mux control types
// Command opcodes and handshake states.
// ================================================

package chan_cfg_pkg;

  `include "chan_mux_params.svh"

  // Host commands.
  typedef enum logic [1:0] {
    OP_SET_CHANNEL = 2'd0,
    OP_BROADCAST   = 2'd1,
    OP_IDENTITY    = 2'd2
  } cfg_opcode_t;

  // Four-phase handshake states.
  typedef enum logic [1:0] {
    CFG_IDLE  = 2'd0,
    CFG_APPLY = 2'd1,
    CFG_ACK   = 2'd2
  } cfg_state_t;

endpackage

// ==== hdl/chan_data_pkg.sv ====
// ================================================
// Channel mux data types
// Samples, source indices and the select table.
// ================================================

package chan_data_pkg;

  `include "chan_mux_params.svh"

  typedef logic [`CHAN_MUX_SAMPLE_WIDTH-1:0] sample_t;

  typedef logic [`CHAN_MUX_SELECT_BITS-1:0] source_idx_t;

  // Entry i holds the source of output i.
  typedef source_idx_t [`CHAN_MUX_OUT_CHANNELS-1:0] select_table_t;

endpackage

// ==== hdl/chan_cfg_slave.sv ====
// ================================================
// Channel mux command slave
// Four-phase req/ack port that decodes host
// commands and owns the select table.
// ================================================

`timescale 1ns/1ps

`include "chan_mux_params.svh"

module chan_cfg_slave
  import chan_cfg_pkg::*;
  import chan_data_pkg::*;
(
  input  logic                               data_clk,
  input  logic                               config_reset,
  input  logic                               cfg_req,
  input  cfg_opcode_t                        cfg_opcode,
  input  logic [`CHAN_MUX_OUT_BITS-1:0]      cfg_channel,
  input  source_idx_t                        cfg_source,
  output logic                               cfg_ack,
  output select_table_t                      select_table,
  output logic [`CHAN_MUX_OUT_CHANNELS-1:0]  table_changed
);

  cfg_state_t                          state;
  cfg_opcode_t                         cmd_opcode;
  logic [`CHAN_MUX_OUT_BITS-1:0]       cmd_channel;
  source_idx_t                         cmd_source;
  select_table_t                       next_table;
  logic [`CHAN_MUX_OUT_CHANNELS-1:0]   next_changed;

  // Output i takes input i.
  function automatic select_table_t identity_table();
    select_table_t tbl;
    for (int i = 0; i < `CHAN_MUX_OUT_CHANNELS; i++) begin
      tbl[i] = source_idx_t'(i);
    end
    return tbl;
  endfunction

  // ================================================
  // Command capture
  // ================================================

  always_ff @(posedge data_clk) begin
    if (state == CFG_IDLE && cfg_req) begin
      cmd_opcode  <= cfg_opcode;
      cmd_channel <= cfg_channel;
      cmd_source  <= cfg_source;
    end
  end

  // New table from the captured command.
  always_comb begin
    next_table = select_table;
    case (cmd_opcode)
      OP_SET_CHANNEL: begin
        for (int i = 0; i < `CHAN_MUX_OUT_CHANNELS; i++) begin
          if (i == cmd_channel) begin
            next_table[i] = cmd_source;
          end
        end
      end
      OP_BROADCAST: begin
        for (int i = 0; i < `CHAN_MUX_OUT_CHANNELS; i++) begin
          next_table[i] = cmd_source;
        end
      end
      OP_IDENTITY: next_table = identity_table();
      default: next_table = select_table;
    endcase
    // Only entries that really move get flagged.
    for (int i = 0; i < `CHAN_MUX_OUT_CHANNELS; i++) begin
      next_changed[i] = (next_table[i] != select_table[i]);
    end
  end

  // ================================================
  // Handshake FSM
  // ================================================

  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      state         <= CFG_IDLE;
      cfg_ack       <= 1'b0;
      select_table  <= identity_table();
      table_changed <= '0;
    end else begin
      table_changed <= '0;
      case (state)
        CFG_IDLE: begin
          if (cfg_req) begin
            state <= CFG_APPLY;
          end
        end
        CFG_APPLY: begin
          select_table  <= next_table;
          table_changed <= next_changed;
          cfg_ack       <= 1'b1;
          state         <= CFG_ACK;
        end
        CFG_ACK: begin
          // Hold ack until the host lets go of req.
          if (!cfg_req) begin
            cfg_ack <= 1'b0;
            state   <= CFG_IDLE;
          end
        end
        default: state <= CFG_IDLE;
      endcase
    end
  end

  a_ack_not_idle: assert property (@(posedge data_clk) disable iff (config_reset)
    (state == CFG_IDLE) |-> !cfg_ack);

  a_source_range: assert property (@(posedge data_clk) disable iff (config_reset)
    (state == CFG_APPLY) |-> (cmd_source < `CHAN_MUX_IN_CHANNELS));

  // Change flags only on the ack rising edge.
  a_changed_on_ack: assert property (@(posedge data_clk) disable iff (config_reset)
    (table_changed != '0) |-> (cfg_ack && !$past(cfg_ack)));

endmodule

// ==== hdl/chan_select_stage.sv ====
// ================================================
// Channel mux select stage
// Stage 1: picks each output's source sample and
// marks outputs whose source just changed.
// ================================================

`timescale 1ns/1ps

`include "chan_mux_params.svh"

module chan_select_stage
  import chan_data_pkg::*;
(
  input  logic                                                      data_clk,
  input  logic                                                      config_reset,
  input  logic [`CHAN_MUX_IN_CHANNELS*`CHAN_MUX_SAMPLE_WIDTH-1:0]   in_data,
  input  logic [`CHAN_MUX_IN_CHANNELS-1:0]                          in_valid,
  input  select_table_t                                             select_table,
  input  logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         table_changed,
  output logic [`CHAN_MUX_OUT_CHANNELS*`CHAN_MUX_SAMPLE_WIDTH-1:0]  s1_data,
  output logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         s1_valid,
  output logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         s1_switch
);

  sample_t                            in_sample [`CHAN_MUX_IN_CHANNELS];
  sample_t                            sel_data  [`CHAN_MUX_OUT_CHANNELS];
  logic [`CHAN_MUX_OUT_CHANNELS-1:0]  sel_valid;

  // Split the flat input bus per channel.
  always_comb begin
    for (int i = 0; i < `CHAN_MUX_IN_CHANNELS; i++) begin
      in_sample[i] = in_data[i*`CHAN_MUX_SAMPLE_WIDTH +: `CHAN_MUX_SAMPLE_WIDTH];
    end
  end

  // ================================================
  // Source mux
  // ================================================

  always_comb begin
    source_idx_t src;
    for (int o = 0; o < `CHAN_MUX_OUT_CHANNELS; o++) begin
      src          = select_table[o];
      sel_data[o]  = in_sample[src];
      sel_valid[o] = in_valid[src];
    end
  end

  // ================================================
  // Stage 1 registers
  // ================================================

  // Switch mark rides with the first sample under the new table.
  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      s1_valid  <= '0;
      s1_switch <= '0;
    end else begin
      s1_valid  <= sel_valid;
      s1_switch <= table_changed;
    end
  end

  always_ff @(posedge data_clk) begin
    for (int o = 0; o < `CHAN_MUX_OUT_CHANNELS; o++) begin
      s1_data[o*`CHAN_MUX_SAMPLE_WIDTH +: `CHAN_MUX_SAMPLE_WIDTH] <= sel_data[o];
    end
  end

  a_valid_after_reset: assert property (@(posedge data_clk)
    config_reset |=> (s1_valid == '0));

endmodule

// ==== hdl/chan_output_stage.sv ====
// ================================================
// Channel mux output stage
// Stage 2: output registers, with valid blanked
// for a few samples after a source switch.
// ================================================

`timescale 1ns/1ps

`include "chan_mux_params.svh"

module chan_output_stage (
  input  logic                                                      data_clk,
  input  logic                                                      config_reset,
  input  logic [`CHAN_MUX_OUT_CHANNELS*`CHAN_MUX_SAMPLE_WIDTH-1:0]  s1_data,
  input  logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         s1_valid,
  input  logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         s1_switch,
  output logic [`CHAN_MUX_OUT_CHANNELS*`CHAN_MUX_SAMPLE_WIDTH-1:0]  out_data,
  output logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         out_valid
);

  localparam int BLANK_BITS = $clog2(`CHAN_MUX_BLANK_CYCLES + 1);

  logic [BLANK_BITS-1:0] blank_cnt  [`CHAN_MUX_OUT_CHANNELS];
  logic [BLANK_BITS-1:0] blank_next [`CHAN_MUX_OUT_CHANNELS];

  // ================================================
  // Blanking counters
  // ================================================

  // Load on switch, then count down to zero.
  always_comb begin
    for (int o = 0; o < `CHAN_MUX_OUT_CHANNELS; o++) begin
      if (s1_switch[o]) begin
        blank_next[o] = BLANK_BITS'(`CHAN_MUX_BLANK_CYCLES);
      end else if (blank_cnt[o] != '0) begin
        blank_next[o] = blank_cnt[o] - 1'b1;
      end else begin
        blank_next[o] = '0;
      end
    end
  end

  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      out_valid <= '0;
      for (int o = 0; o < `CHAN_MUX_OUT_CHANNELS; o++) begin
        blank_cnt[o] <= '0;
      end
    end else begin
      for (int o = 0; o < `CHAN_MUX_OUT_CHANNELS; o++) begin
        blank_cnt[o] <= blank_next[o];
        // Gate on the loaded count so the window is exactly N samples.
        out_valid[o] <= s1_valid[o] && (blank_next[o] == '0);
      end
    end
  end

  // Payload register.
  always_ff @(posedge data_clk) begin
    out_data <= s1_data;
  end

  // A switch blanks the next N output samples.
  for (genvar o = 0; o < `CHAN_MUX_OUT_CHANNELS; o++) begin : g_blank_chk
    a_blank_holds: assert property (@(posedge data_clk) disable iff (config_reset)
      s1_switch[o] |=> !out_valid[o] [*`CHAN_MUX_BLANK_CYCLES]);
  end

endmodule

// ==== hdl/chan_mux_top.sv ====
// ================================================
// Channel mux top level
// Command slave feeding a two-stage select and
// output pipeline.
// ================================================

`timescale 1ns/1ps

`include "chan_mux_params.svh"

module chan_mux_top
  import chan_cfg_pkg::*;
  import chan_data_pkg::*;
(
  input  logic                                                      data_clk,
  input  logic                                                      config_reset,
  // Data in.
  input  logic [`CHAN_MUX_IN_CHANNELS*`CHAN_MUX_SAMPLE_WIDTH-1:0]   in_data,
  input  logic [`CHAN_MUX_IN_CHANNELS-1:0]                          in_valid,
  // Data out.
  output logic [`CHAN_MUX_OUT_CHANNELS*`CHAN_MUX_SAMPLE_WIDTH-1:0]  out_data,
  output logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         out_valid,
  // Command port.
  input  logic                                                      cfg_req,
  input  cfg_opcode_t                                               cfg_opcode,
  input  logic [`CHAN_MUX_OUT_BITS-1:0]                             cfg_channel,
  input  source_idx_t                                               cfg_source,
  output logic                                                      cfg_ack
);

  select_table_t                                             select_table;
  logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         table_changed;
  logic [`CHAN_MUX_OUT_CHANNELS*`CHAN_MUX_SAMPLE_WIDTH-1:0]  s1_data;
  logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         s1_valid;
  logic [`CHAN_MUX_OUT_CHANNELS-1:0]                         s1_switch;

  chan_cfg_slave u_cfg_slave (
    .data_clk      (data_clk),
    .config_reset  (config_reset),
    .cfg_req       (cfg_req),
    .cfg_opcode    (cfg_opcode),
    .cfg_channel   (cfg_channel),
    .cfg_source    (cfg_source),
    .cfg_ack       (cfg_ack),
    .select_table  (select_table),
    .table_changed (table_changed)
  );

  chan_select_stage u_select_stage (
    .data_clk      (data_clk),
    .config_reset  (config_reset),
    .in_data       (in_data),
    .in_valid      (in_valid),
    .select_table  (select_table),
    .table_changed (table_changed),
    .s1_data       (s1_data),
    .s1_valid      (s1_valid),
    .s1_switch     (s1_switch)
  );

  chan_output_stage u_output_stage (
    .data_clk     (data_clk),
    .config_reset (config_reset),
    .s1_data      (s1_data),
    .s1_valid     (s1_valid),
    .s1_switch    (s1_switch),
    .out_data     (out_data),
    .out_valid    (out_valid)
  );

endmodule

// ==== sim/chan_mux_tb.sv ====
// ================================================
// Channel mux testbench
// Directed tests of routing, blanking and the
// four-phase command handshake.
// ================================================

`timescale 1ns/1ps

`include "chan_mux_params.svh"

module chan_mux_tb
  import chan_cfg_pkg::*;
  import chan_data_pkg::*;
();

  localparam int IN_CH      = `CHAN_MUX_IN_CHANNELS;
  localparam int OUT_CH     = `CHAN_MUX_OUT_CHANNELS;
  localparam int SW         = `CHAN_MUX_SAMPLE_WIDTH;
  localparam int OUT_BITS   = `CHAN_MUX_OUT_BITS;
  localparam int BLANK      = `CHAN_MUX_BLANK_CYCLES;
  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS  = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 400 + 100;

  logic                      data_clk;
  logic                      config_reset;
  logic [IN_CH*SW-1:0]       in_data;
  logic [IN_CH-1:0]          in_valid;
  logic [OUT_CH*SW-1:0]      out_data;
  logic [OUT_CH-1:0]         out_valid;
  logic                      cfg_req;
  cfg_opcode_t               cfg_opcode;
  logic [OUT_BITS-1:0]       cfg_channel;
  source_idx_t               cfg_source;
  logic                      cfg_ack;

  // Reference model state.
  int                        model_src [OUT_CH];
  sample_t                   hist_data [2][IN_CH];
  logic [IN_CH-1:0]          hist_valid [2];
  sample_t                   exp_data [OUT_CH];
  logic [OUT_CH-1:0]         exp_valid;
  logic [OUT_CH-1:0]         check_mask;
  int                        cycle_cnt;
  int                        ack_cycle;
  int                        error_count;

  chan_mux_top DUT (
    .data_clk     (data_clk),
    .config_reset (config_reset),
    .in_data      (in_data),
    .in_valid     (in_valid),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .cfg_req      (cfg_req),
    .cfg_opcode   (cfg_opcode),
    .cfg_channel  (cfg_channel),
    .cfg_source   (cfg_source),
    .cfg_ack      (cfg_ack)
  );

  initial data_clk = 1'b0;
  always #(CLK_PERIOD / 2) data_clk = ~data_clk;

  always @(posedge data_clk) begin
    if (config_reset) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles.", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $fatal(1, "Watchdog expired.");
  end

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopping at the first error.");
  endtask

  // Advance to the sampling point of the next cycle.
  task automatic next_cycle();
    @(posedge data_clk);
    #3;
  endtask

  task automatic wait_until_cycle(input int n);
    while (cycle_cnt < n) begin
      next_cycle();
    end
  endtask

  // ================================================
  // Stimulus and continuous checking
  // ================================================

  task automatic stream_samples();
    int      src;
    sample_t s;
    forever begin
      @(posedge data_clk);
      #1;
      // Output after this edge comes from the input driven two edges back.
      for (int o = 0; o < OUT_CH; o++) begin
        src          = model_src[o];
        exp_data[o]  = hist_data[1][src];
        exp_valid[o] = hist_valid[1][src];
        if (check_mask[o]) begin
          assert (out_valid[o] === exp_valid[o] && out_data[o*SW +: SW] === exp_data[o])
            else report_failure($sformatf(
              "mismatch at %0t: output %0d got %h/%b, expected %h/%b", $time, o,
              out_data[o*SW +: SW], out_valid[o], exp_data[o], exp_valid[o]));
        end
      end
      for (int i = 0; i < IN_CH; i++) begin
        hist_data[1][i] = hist_data[0][i];
        s               = sample_t'($urandom());
        hist_data[0][i] = s;
        in_data[i*SW +: SW] = s;
      end
      hist_valid[1] = hist_valid[0];
      in_valid      = IN_CH'($urandom());
      hist_valid[0] = in_valid;
    end
  endtask

  // ================================================
  // Command helpers
  // ================================================

  task automatic cfg_command(input cfg_opcode_t op, input int ch, input int src,
                             input int hold);
    int waited;
    @(posedge data_clk);
    #1;
    cfg_opcode  = op;
    cfg_channel = OUT_BITS'(ch);
    cfg_source  = source_idx_t'(src);
    cfg_req     = 1'b1;
    waited      = 0;
    while (cfg_ack !== 1'b1) begin
      assert (waited < 8) else report_failure("cfg_ack did not rise within 8 cycles.");
      @(posedge data_clk);
      #1;
      waited++;
    end
    ack_cycle = cycle_cnt;
    repeat (hold) begin
      @(posedge data_clk);
      #1;
      assert (cfg_ack === 1'b1)
        else report_failure($sformatf("mismatch at %0t: cfg_ack low while cfg_req held",
                                      $time));
    end
    cfg_req = 1'b0;
    waited  = 0;
    while (cfg_ack !== 1'b0) begin
      assert (waited < 8) else report_failure("cfg_ack did not fall within 8 cycles.");
      @(posedge data_clk);
      #1;
      waited++;
    end
    #2;
  endtask

  task automatic check_blanked(input logic [OUT_CH-1:0] changed);
    for (int o = 0; o < OUT_CH; o++) begin
      if (changed[o]) begin
        assert (out_valid[o] === 1'b0 && out_data[o*SW +: SW] === exp_data[o])
          else report_failure($sformatf(
            "mismatch at %0t: output %0d not blanked or wrong data %h, expected %h",
            $time, o, out_data[o*SW +: SW], exp_data[o]));
      end
    end
  endtask

  // Issues one command, checks the blanking window, then checks all outputs.
  task automatic run_command(input cfg_opcode_t op, input int ch, input int src,
                             input int hold, input int idle);
    int              new_src [OUT_CH];
    logic [OUT_CH-1:0] changed;
    for (int o = 0; o < OUT_CH; o++) begin
      case (op)
        OP_SET_CHANNEL: new_src[o] = (o == ch) ? src : model_src[o];
        OP_BROADCAST:   new_src[o] = src;
        default:        new_src[o] = o;
      endcase
      changed[o] = (new_src[o] != model_src[o]);
    end
    check_mask = ~changed;
    cfg_command(op, ch, src, hold);
    for (int o = 0; o < OUT_CH; o++) begin
      model_src[o] = new_src[o];
    end
    if (hold == 0) begin
      for (int k = 0; k < BLANK; k++) begin
        wait_until_cycle(ack_cycle + 2 + k);
        check_blanked(changed);
      end
    end
    wait_until_cycle(ack_cycle + 1 + BLANK);
    check_mask = '1;
    repeat (idle) next_cycle();
  endtask

  function automatic int pick_new_source(input int ch);
    int src;
    src = $urandom_range(IN_CH - 1, 0);
    while (src == model_src[ch]) begin
      src = $urandom_range(IN_CH - 1, 0);
    end
    return src;
  endfunction

  // ================================================
  // Tests
  // ================================================

  task automatic test_reset();
    repeat (4) begin
      @(posedge data_clk);
      #1;
      assert (cfg_ack === 1'b0 && out_valid === '0)
        else report_failure($sformatf("mismatch at %0t: outputs active during reset", $time));
    end
    config_reset = 1'b0;
    @(posedge data_clk);
    #1;
    assert (cfg_ack === 1'b0 && out_valid === '0)
      else report_failure($sformatf("mismatch at %0t: outputs active after reset", $time));
    #2;
    check_mask = '1;
    repeat (30) next_cycle();
  endtask

  task automatic test_set_channel();
    int ch;
    repeat (3) begin
      ch = $urandom_range(OUT_CH - 1, 0);
      run_command(OP_SET_CHANNEL, ch, pick_new_source(ch), 0, 40);
    end
  endtask

  task automatic test_broadcast();
    run_command(OP_BROADCAST, 0, $urandom_range(IN_CH - 1, 0), 0, 40);
    run_command(OP_BROADCAST, 0, $urandom_range(IN_CH - 1, 0), 0, 40);
  endtask

  task automatic test_blanking();
    run_command(OP_IDENTITY, 0, 0, 0, 20);
    // Source 1 leaves output 1 untouched.
    run_command(OP_BROADCAST, 0, 1, 0, 200);
  endtask

  task automatic test_identity_handshake();
    for (int o = 0; o < OUT_CH; o++) begin
      run_command(OP_SET_CHANNEL, o, pick_new_source(o), 0, 30);
    end
    run_command(OP_IDENTITY, 0, 0, 0, 30);
    run_command(OP_SET_CHANNEL, 1, 5, 10, 30);
    run_command(OP_SET_CHANNEL, 1, 5, 10, 30);
  endtask

  initial begin : main
    config_reset = 1'b1;
    cfg_req      = 1'b0;
    cfg_opcode   = OP_SET_CHANNEL;
    cfg_channel  = '0;
    cfg_source   = '0;
    in_data      = '0;
    in_valid     = '0;
    check_mask   = '0;
    error_count  = 0;
    ack_cycle    = 0;
    exp_valid    = '0;
    for (int o = 0; o < OUT_CH; o++) begin
      model_src[o] = o;
      exp_data[o]  = '0;
    end
    for (int i = 0; i < IN_CH; i++) begin
      hist_data[0][i] = '0;
      hist_data[1][i] = '0;
    end
    hist_valid[0] = '0;
    hist_valid[1] = '0;
    void'($urandom(32'h6bfeb71f));
    fork
      stream_samples();
    join_none
    test_reset();
    test_set_channel();
    test_broadcast();
    test_blanking();
    test_identity_handshake();
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/chan_cfg_pkg.sv
hdl/chan_data_pkg.sv
hdl/chan_cfg_slave.sv
hdl/chan_select_stage.sv
hdl/chan_output_stage.sv
hdl/chan_mux_top.sv
sim/chan_mux_tb.sv
